// ==== dv/coreTests.txt ====
# name  instruction(hex)  valid  dest(decimal)  data(hex)
# a line named reset restarts the core and carries no instruction
add_zero     00221820 1 3  00000000
addi_pos     20010005 1 1  00000005
addi_neg     2002fffd 1 2  fffffffd
ori_zext     34048001 1 4  00008001
andi_zext    3045ff0f 1 5  0000ff0d
slti_true    28460001 1 6  00000001
slti_false   2827ffff 1 7  00000000
lui_upper    3c081234 1 8  12340000
add_regs     00224820 1 9  00000002
sub_regs     00225022 1 10 00000008
and_regs     00855824 1 11 00008001
or_regs      00886025 1 12 12348001
nor_regs     00266827 1 13 fffffffa
slt_true     0041702a 1 14 00000001
slt_false    0022782a 1 15 00000000
dep_base     2030000a 1 16 0000000f
dep_incr     22100001 1 16 00000010
dep_double   02108820 1 17 00000020
dep_sub      02309022 1 18 00000010
write_r0     20200007 1 0  0000000c
read_r0      00019825 1 19 00000005
bad_opcode   8c220000 0 0  00000000
bad_funct    00220018 0 0  00000000
ori_after    36740000 1 20 00000005
reset        00000000 0 0  00000000
add_cleared  0022a820 1 21 00000000
or_cleared   0208b025 1 22 00000000
addi_cleared 22370001 1 23 00000001

// ==== list.f ====
logic/mipsPkg.sv
logic/instrDecode.sv
logic/regFile.sv
logic/aluExecute.sv
logic/writeResult.sv
logic/mipsCore.sv
dv/core_assert.sv
dv/coreCheck.sv
dv/coreTb.sv

// ==== run.sh ====
#!/bin/bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f list.f --top-module coreTb -o coreSim
output=$(./obj_dir/coreSim +verilator+error+limit+100)
echo "$output"
if echo "$output" | grep -qx "Done: no errors"; then
	exit 0
fi
exit 1

// ==== dv/coreTb.sv ====
module coreTb;

	logic clk;
	logic reset;
	logic [31:0] instr;
	logic instrValid;
	logic resultValid;
	logic [4:0] resultReg;
	logic [31:0] resultData;
	logic [31:0] retireCount;

	// Expectation of the word on the bus, then of the word just accepted
	logic [127:0] curName;
	logic curValid;
	logic [4:0] curDest;
	logic [31:0] curData;
	logic expCheck;
	logic [127:0] expName;
	logic expValid;
	logic [4:0] expDest;
	logic [31:0] expData;

	// Test table, names packed as up to 16 characters
	logic [127:0] names [$];
	logic [31:0] words [$];
	logic validFlags [$];
	logic [4:0] dests [$];
	logic [31:0] datas [$];

	int valueErrors;
	int unexpectedErrors;
	int fileErrors = 0;
	int cycleCount = 0;
	int cycleLimit = 0;
	// Idle-gap generator state
	logic [15:0] lfsr = 16'd2;

	mipsCore uut (.clk(clk), .reset(reset), .instr(instr), .instrValid(instrValid),
		.resultValid(resultValid), .resultReg(resultReg), .resultData(resultData),
		.retireCount(retireCount));

	coreCheck check (.clk(clk), .reset(reset), .resultValid(resultValid),
		.resultReg(resultReg), .resultData(resultData), .retireCount(retireCount),
		.expCheck(expCheck), .expName(expName), .expValid(expValid), .expDest(expDest),
		.expData(expData), .valueErrors(valueErrors), .unexpectedErrors(unexpectedErrors));

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Expectation moves on at the edge that accepts the word
	always @(posedge clk)
	begin
		expCheck <= instrValid;
		expName <= curName;
		expValid <= curValid;
		expDest <= curDest;
		expData <= curData;
	end

	// Run limit from the test count
	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleLimit > 0 && cycleCount >= cycleLimit)
		begin
			$display("Timeout: the tests did not finish within %0d cycles", cycleLimit);
			$display("Done: errors found");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////

	// Right-justified like a scanned name
	function automatic logic [127:0] packName(input string text);
		logic [127:0] bits;
		bits = '0;
		for (int k = 0; k < text.len() && k < 16; k++)
			bits = {bits[119:0], text.getc(k)};
		return bits;
	endfunction

	// 16-bit Fibonacci, taps 16 14 13 11
	function automatic logic [15:0] lfsrNext(input logic [15:0] state);
		logic feedback;
		feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
		return {state[14:0], feedback};
	endfunction

	task automatic loadTests(input int fid);
		string line;
		int fields;
		logic [127:0] nameIn;
		logic [31:0] wordIn;
		int validIn;
		int destIn;
		logic [31:0] dataIn;
		while (!$feof(fid))
		begin
			line = "";
			void'($fgets(line, fid));
			nameIn = '0;
			// Skip blanks and column notes
			if (line.len() > 1 && line.getc(0) != "#")
			begin
				fields = $sscanf(line, "%s %h %d %d %h", nameIn, wordIn, validIn, destIn,
					dataIn);
				if (fields == 5)
				begin
					names.push_back(nameIn);
					words.push_back(wordIn);
					validFlags.push_back(validIn[0]);
					dests.push_back(destIn[4:0]);
					datas.push_back(dataIn);
				end
				else
				begin
					$display("Malformed line in the test file: %s", line);
					fileErrors = fileErrors + 1;
				end
			end
		end
		$fclose(fid);
		if (names.size() == 0)
		begin
			$display("The test file holds no tests");
			fileErrors = fileErrors + 1;
		end
	endtask

	// Three reset cycles with the bus idle
	task automatic applyReset();
		@(posedge clk);
		instrValid <= 1'b0;
		reset <= 1'b1;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
	endtask

	task automatic runTests();
		for (int i = 0; i < names.size(); i++)
		begin
			if (names[i] == packName("reset"))
				applyReset();
			else
			begin
				@(posedge clk);
				instr <= words[i];
				instrValid <= 1'b1;
				curName <= names[i];
				curValid <= validFlags[i];
				curDest <= dests[i];
				curData <= datas[i];
			end
			// One LFSR bit per idle decision
			lfsr = lfsrNext(lfsr);
			if (lfsr[0])
			begin
				@(posedge clk);
				instrValid <= 1'b0;
			end
		end
		@(posedge clk);
		instrValid <= 1'b0;
		// Last result appears one cycle after acceptance
		repeat (2) @(posedge clk);
	endtask

	task automatic report();
		int total;
		total = valueErrors + unexpectedErrors + fileErrors + uut.checks.assertFails;
		$display("Errors: %0d value, %0d unexpected result, %0d test file, %0d assertion",
			valueErrors, unexpectedErrors, fileErrors, uut.checks.assertFails);
		if (total == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		int fid;
		reset = 1'b1;
		instr = '0;
		instrValid = 1'b0;
		curName = '0;
		curValid = 1'b0;
		curDest = '0;
		curData = '0;
		fid = $fopen("dv/coreTests.txt", "r");
		if (fid == 0)
		begin
			$display("Cannot open the test file dv/coreTests.txt");
			$display("Done: errors found");
			$finish;
		end
		else
		begin
			loadTests(fid);
			cycleLimit = 2 * names.size() + 20;
			repeat (3) @(posedge clk);
			reset <= 1'b0;
			runTests();
			report();
		end
	end

endmodule

// ==== dv/coreCheck.sv ====
module coreCheck
(
	input logic clk,
	input logic reset,
	input logic resultValid,
	input logic [4:0] resultReg,
	input logic [31:0] resultData,
	input logic [31:0] retireCount,
	input logic expCheck,
	input logic [127:0] expName,
	input logic expValid,
	input logic [4:0] expDest,
	input logic [31:0] expData,
	output int valueErrors,
	output int unexpectedErrors
);

	int valueCount = 0;
	int unexpectedCount = 0;
	// Results retired before the current cycle
	logic [31:0] expCount = '0;
	// Most recent accepted test, for count errors
	logic [127:0] lastName = '0;

	assign valueErrors = valueCount;
	assign unexpectedErrors = unexpectedCount;

	// Outputs settle after the rising edge, sampled on the falling one
	always @(negedge clk)
	begin
		if (expCheck === 1'b1)
		begin
			lastName = expName;
			if (resultValid !== expValid)
			begin
				$display("ERROR %0s resultValid expected %0b actual %0b", expName, expValid,
					resultValid);
				valueCount = valueCount + 1;
			end
			else if (expValid)
			begin
				if (resultReg !== expDest)
				begin
					$display("ERROR %0s resultReg expected %0d actual %0d", expName, expDest,
						resultReg);
					valueCount = valueCount + 1;
				end
				if (resultData !== expData)
				begin
					$display("ERROR %0s resultData expected %h actual %h", expName, expData,
						resultData);
					valueCount = valueCount + 1;
				end
			end
		end
		else if (reset === 1'b0 && resultValid !== 1'b0)
		begin
			$display("A result for register %0d appeared with no instruction accepted",
				resultReg);
			unexpectedCount = unexpectedCount + 1;
		end
		// Count restarts with the core
		if (reset !== 1'b0)
			expCount = '0;
		else
		begin
			if (retireCount !== expCount)
			begin
				$display("ERROR %0s retireCount expected %0d actual %0d", lastName, expCount,
					retireCount);
				valueCount = valueCount + 1;
			end
			// Retires at the coming edge
			if (expCheck === 1'b1 && expValid === 1'b1)
				expCount = expCount + 32'd1;
		end
	end

endmodule

// ==== dv/core_assert.sv ====
module core_assert
(
	input logic clk,
	input logic reset,
	input logic resultValid,
	input logic [4:0] readAddr1,
	input logic [4:0] readAddr2,
	input logic [31:0] readData1,
	input logic [31:0] readData2,
	input logic [31:0] retireCount
);

	// Running count of assertion failures
	int assertFails = 0;

	// Write-back stage empty one cycle after reset
	resetEmpty: assert property (@(posedge clk) reset |=> !resultValid)
	else
	begin
		assertFails = assertFails + 1;
		$error("resultValid high in the cycle after reset");
	end

	// Register 0 reads as zero on both ports, write-through included
	zeroReads: assert property (@(posedge clk) disable iff (reset)
		(readAddr1 != '0 || readData1 == '0) && (readAddr2 != '0 || readData2 == '0))
	else
	begin
		assertFails = assertFails + 1;
		$error("register 0 read back a nonzero value");
	end

	// One count per write-back cycle
	countStep: assert property (@(posedge clk) disable iff (reset)
		1'b1 |=> retireCount == $past(retireCount) + ($past(resultValid) ? 32'd1 : 32'd0))
	else
	begin
		assertFails = assertFails + 1;
		$error("retireCount did not follow resultValid");
	end

endmodule

bind mipsCore core_assert checks (.clk(clk), .reset(reset), .resultValid(resultValid),
	.readAddr1(readAddr1), .readAddr2(readAddr2), .readData1(readData1),
	.readData2(readData2), .retireCount(retireCount));

// ==== logic/mipsCore.sv ====
module mipsCore
(
	input logic clk,
	input logic reset,
	input logic [31:0] instr,
	input logic instrValid,
	output logic resultValid,
	output logic [4:0] resultReg,
	output logic [31:0] resultData,
	output logic [31:0] retireCount
);

	// Decode to register file and ALU
	logic [mipsPkg::regAddrWidth-1:0] readAddr1;
	logic [mipsPkg::regAddrWidth-1:0] readAddr2;
	logic [mipsPkg::regAddrWidth-1:0] destReg;
	logic [15:0] imm;
	mipsPkg::aluOp_t aluOp;
	logic useImm;
	logic zeroExtend;
	logic issue;
	// Register read data
	logic [mipsPkg::dataWidth-1:0] readData1;
	logic [mipsPkg::dataWidth-1:0] readData2;
	// Execute stage register
	logic exValid;
	logic [mipsPkg::regAddrWidth-1:0] exDest;
	logic [mipsPkg::dataWidth-1:0] exData;
	// Write-back port
	logic writeEnable;
	logic [mipsPkg::regAddrWidth-1:0] writeAddr;
	logic [mipsPkg::dataWidth-1:0] writeData;

	////////////////////////////////////////////////////////////////////////////
	// Stages
	////////////////////////////////////////////////////////////////////////////

	instrDecode decode (.instr(instr), .instrValid(instrValid), .readAddr1(readAddr1),
		.readAddr2(readAddr2), .destReg(destReg), .imm(imm), .aluOp(aluOp),
		.useImm(useImm), .zeroExtend(zeroExtend), .issue(issue));

	regFile regs (.clk(clk), .reset(reset), .readAddr1(readAddr1), .readAddr2(readAddr2),
		.readData1(readData1), .readData2(readData2), .writeEnable(writeEnable),
		.writeAddr(writeAddr), .writeData(writeData));

	aluExecute execute (.clk(clk), .reset(reset), .readData1(readData1),
		.readData2(readData2), .imm(imm), .useImm(useImm), .zeroExtend(zeroExtend),
		.aluOp(aluOp), .destReg(destReg), .issue(issue), .exValid(exValid),
		.exDest(exDest), .exData(exData));

	writeResult writeBack (.clk(clk), .reset(reset), .exValid(exValid), .exDest(exDest),
		.exData(exData), .writeEnable(writeEnable), .writeAddr(writeAddr),
		.writeData(writeData), .resultValid(resultValid), .resultReg(resultReg),
		.resultData(resultData), .retireCount(retireCount));

endmodule

// ==== logic/writeResult.sv ====
module writeResult
(
	input logic clk,
	input logic reset,
	input logic exValid,
	input logic [mipsPkg::regAddrWidth-1:0] exDest,
	input logic [mipsPkg::dataWidth-1:0] exData,
	output logic writeEnable,
	output logic [mipsPkg::regAddrWidth-1:0] writeAddr,
	output logic [mipsPkg::dataWidth-1:0] writeData,
	output logic resultValid,
	output logic [mipsPkg::regAddrWidth-1:0] resultReg,
	output logic [mipsPkg::dataWidth-1:0] resultData,
	output logic [31:0] retireCount
);

	////////////////////////////////////////////////////////////////////////////
	// Register write port
	////////////////////////////////////////////////////////////////////////////

	// Register 0 stays zero, so its writes are dropped here
	assign writeEnable = exValid && (exDest != '0);
	assign writeAddr = exDest;
	assign writeData = exData;

	// Result reported even for destination 0
	assign resultValid = exValid;
	assign resultReg = exDest;
	assign resultData = exData;

	////////////////////////////////////////////////////////////////////////////
	// Retire counter
	////////////////////////////////////////////////////////////////////////////

	// One count per write-back cycle
	always_ff @(posedge clk)
	begin
		if (reset)
			retireCount <= '0;
		else if (exValid)
			retireCount <= retireCount + 32'd1;
	end

endmodule

// ==== logic/aluExecute.sv ====
module aluExecute
(
	input logic clk,
	input logic reset,
	input logic [mipsPkg::dataWidth-1:0] readData1,
	input logic [mipsPkg::dataWidth-1:0] readData2,
	input logic [15:0] imm,
	input logic useImm,
	input logic zeroExtend,
	input mipsPkg::aluOp_t aluOp,
	input logic [mipsPkg::regAddrWidth-1:0] destReg,
	input logic issue,
	output logic exValid,
	output logic [mipsPkg::regAddrWidth-1:0] exDest,
	output logic [mipsPkg::dataWidth-1:0] exData
);

	////////////////////////////////////////////////////////////////////////////
	// Operand B
	////////////////////////////////////////////////////////////////////////////

	logic [mipsPkg::dataWidth-1:0] immExt;
	logic [mipsPkg::dataWidth-1:0] opB;
	logic [mipsPkg::dataWidth-1:0] aluResult;

	// andi and ori take zero fill, the rest sign fill
	assign immExt = zeroExtend ? {16'h0000, imm} : {{16{imm[15]}}, imm};
	assign opB = useImm ? immExt : readData2;

	////////////////////////////////////////////////////////////////////////////
	// ALU
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		case (aluOp)
			mipsPkg::aluAdd: aluResult = readData1 + opB;
			mipsPkg::aluSub: aluResult = readData1 - opB;
			mipsPkg::aluAnd: aluResult = readData1 & opB;
			mipsPkg::aluOr: aluResult = readData1 | opB;
			mipsPkg::aluNor: aluResult = ~(readData1 | opB);
			// One in bit 0 when rs is less, signed
			mipsPkg::aluSlt: aluResult = {31'd0, $signed(readData1) < $signed(opB)};
			// Upper half from the immediate, lower half zero
			mipsPkg::aluLui: aluResult = {imm, 16'h0000};
			default: aluResult = '0;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Stage register
	////////////////////////////////////////////////////////////////////////////

	// Only the valid flag is control state
	always_ff @(posedge clk)
	begin
		if (reset)
			exValid <= 1'b0;
		else
			exValid <= issue;
	end

	// Payload held until the next issued instruction
	always_ff @(posedge clk)
	begin
		if (issue)
		begin
			exDest <= destReg;
			exData <= aluResult;
		end
	end

endmodule

// ==== logic/regFile.sv ====
module regFile
(
	input logic clk,
	input logic reset,
	input logic [mipsPkg::regAddrWidth-1:0] readAddr1,
	input logic [mipsPkg::regAddrWidth-1:0] readAddr2,
	output logic [mipsPkg::dataWidth-1:0] readData1,
	output logic [mipsPkg::dataWidth-1:0] readData2,
	input logic writeEnable,
	input logic [mipsPkg::regAddrWidth-1:0] writeAddr,
	input logic [mipsPkg::dataWidth-1:0] writeData
);

	////////////////////////////////////////////////////////////////////////////
	// Register array
	////////////////////////////////////////////////////////////////////////////

	logic [mipsPkg::dataWidth-1:0] regs [mipsPkg::numRegs];
	// Write port hits each read port
	logic bypass1;
	logic bypass2;

	// Cleared as a block on reset
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < mipsPkg::numRegs; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (writeEnable)
		begin
			// Address 0 never arrives here with writeEnable set
			regs[writeAddr] <= writeData;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Read ports with write-through
	////////////////////////////////////////////////////////////////////////////

	assign bypass1 = writeEnable && (writeAddr == readAddr1);
	assign bypass2 = writeEnable && (writeAddr == readAddr2);

	// Same-cycle write seen by the dependent read
	assign readData1 = bypass1 ? writeData : regs[readAddr1];
	assign readData2 = bypass2 ? writeData : regs[readAddr2];

endmodule

// ==== logic/instrDecode.sv ====
module instrDecode
(
	input logic [mipsPkg::dataWidth-1:0] instr,
	input logic instrValid,
	output logic [mipsPkg::regAddrWidth-1:0] readAddr1,
	output logic [mipsPkg::regAddrWidth-1:0] readAddr2,
	output logic [mipsPkg::regAddrWidth-1:0] destReg,
	output logic [15:0] imm,
	output mipsPkg::aluOp_t aluOp,
	output logic useImm,
	output logic zeroExtend,
	output logic issue
);

	////////////////////////////////////////////////////////////////////////////
	// Field split
	////////////////////////////////////////////////////////////////////////////

	logic [5:0] opcode;
	logic [5:0] funct;
	logic [mipsPkg::regAddrWidth-1:0] rdField;
	// Low when opcode or funct is not in the supported set
	logic supported;

	assign opcode = instr[31:26];
	assign funct = instr[5:0];
	assign rdField = instr[15:11];

	// rs and rt always feed the read ports
	assign readAddr1 = instr[25:21];
	assign readAddr2 = instr[20:16];
	assign imm = instr[15:0];

	// R-type writes rd, I-type writes rt
	assign destReg = (opcode == mipsPkg::opRType) ? rdField : instr[20:16];

	////////////////////////////////////////////////////////////////////////////
	// Control decode
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		// Defaults for a plain register add
		aluOp = mipsPkg::aluAdd;
		useImm = 1'b0;
		zeroExtend = 1'b0;
		supported = 1'b1;
		case (opcode)
			mipsPkg::opRType:
			begin
				// Operation taken from funct
				case (funct)
					mipsPkg::functAdd: aluOp = mipsPkg::aluAdd;
					mipsPkg::functSub: aluOp = mipsPkg::aluSub;
					mipsPkg::functAnd: aluOp = mipsPkg::aluAnd;
					mipsPkg::functOr: aluOp = mipsPkg::aluOr;
					mipsPkg::functNor: aluOp = mipsPkg::aluNor;
					mipsPkg::functSlt: aluOp = mipsPkg::aluSlt;
					default: supported = 1'b0;
				endcase
			end
			mipsPkg::opAddi:
			begin
				aluOp = mipsPkg::aluAdd;
				useImm = 1'b1;
			end
			mipsPkg::opSlti:
			begin
				// Signed compare against sign-extended immediate
				aluOp = mipsPkg::aluSlt;
				useImm = 1'b1;
			end
			mipsPkg::opAndi:
			begin
				aluOp = mipsPkg::aluAnd;
				useImm = 1'b1;
				zeroExtend = 1'b1;
			end
			mipsPkg::opOri:
			begin
				aluOp = mipsPkg::aluOr;
				useImm = 1'b1;
				zeroExtend = 1'b1;
			end
			mipsPkg::opLui:
			begin
				aluOp = mipsPkg::aluLui;
				useImm = 1'b1;
			end
			default: supported = 1'b0;
		endcase
	end

	// Unsupported words are accepted but never issued
	assign issue = instrValid & supported;

endmodule

// ==== logic/mipsPkg.sv ====
package mipsPkg;

	////////////////////////////////////////////////////////////////////////////
	// Datapath sizes
	////////////////////////////////////////////////////////////////////////////

	// Register and data word width
	localparam int dataWidth = 32;
	// Register index width
	localparam int regAddrWidth = 5;
	// Entries in the register file
	localparam int numRegs = 32;

	////////////////////////////////////////////////////////////////////////////
	// Opcode field values in bits 31..26
	////////////////////////////////////////////////////////////////////////////

	// All R-type share opcode zero
	localparam logic [5:0] opRType = 6'h00;
	localparam logic [5:0] opAddi = 6'h08;
	localparam logic [5:0] opSlti = 6'h0A;
	// Logic immediates use zero extension
	localparam logic [5:0] opAndi = 6'h0C;
	localparam logic [5:0] opOri = 6'h0D;
	// Load upper immediate
	localparam logic [5:0] opLui = 6'h0F;

	////////////////////////////////////////////////////////////////////////////
	// Funct field values in bits 5..0 for R-type
	////////////////////////////////////////////////////////////////////////////

	localparam logic [5:0] functAdd = 6'h20;
	localparam logic [5:0] functSub = 6'h22;
	localparam logic [5:0] functAnd = 6'h24;
	localparam logic [5:0] functOr = 6'h25;
	localparam logic [5:0] functNor = 6'h27;
	// Set on signed less-than
	localparam logic [5:0] functSlt = 6'h2A;

	////////////////////////////////////////////////////////////////////////////
	// ALU operation select
	////////////////////////////////////////////////////////////////////////////

	// One code per ALU function
	typedef enum logic [2:0]
	{
		aluAdd = 3'd0,
		aluSub = 3'd1,
		aluAnd = 3'd2,
		aluOr = 3'd3,
		aluNor = 3'd4,
		aluSlt = 3'd5,
		// Immediate moved to upper half
		aluLui = 3'd6
	} aluOp_t;

endpackage
